// ==== design/id_pkg.sv ====
`default_nettype none

package id_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // major opcodes, inst[31:26] and inst[31:25]
    localparam logic [5:0] op6_alu3r = 6'h00;
    localparam logic [5:0] op6_alui  = 6'h00;  // shares the 3r major code
    localparam logic [5:0] op6_mem   = 6'h0a;
    localparam logic [5:0] op6_jirl  = 6'h13;
    localparam logic [5:0] op6_b     = 6'h14;
    localparam logic [5:0] op6_bl    = 6'h15;
    localparam logic [5:0] op6_beq   = 6'h16;
    localparam logic [5:0] op6_bne   = 6'h17;
    localparam logic [5:0] op6_blt   = 6'h18;
    localparam logic [5:0] op6_bge   = 6'h19;
    localparam logic [5:0] op6_bltu  = 6'h1a;
    localparam logic [5:0] op6_bgeu  = 6'h1b;

    localparam logic [6:0] op7_lu12i     = 7'h0a;
    localparam logic [6:0] op7_pcaddu12i = 7'h0e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // minor codes, inst[25:22], inst[21:20], inst[19:15]
    localparam logic [3:0] op4_3r     = 4'h0;
    localparam logic [1:0] op2_3r     = 2'h1;
    localparam logic [3:0] op4_shifti = 4'h1;
    localparam logic [1:0] op2_shifti = 2'h0;

    localparam logic [4:0] op5_add  = 5'h00;
    localparam logic [4:0] op5_sub  = 5'h02;
    localparam logic [4:0] op5_slt  = 5'h04;
    localparam logic [4:0] op5_sltu = 5'h05;
    localparam logic [4:0] op5_nor  = 5'h08;
    localparam logic [4:0] op5_and  = 5'h09;
    localparam logic [4:0] op5_or   = 5'h0a;
    localparam logic [4:0] op5_xor  = 5'h0b;
    localparam logic [4:0] op5_sll  = 5'h0e;
    localparam logic [4:0] op5_srl  = 5'h0f;
    localparam logic [4:0] op5_sra  = 5'h10;
    localparam logic [4:0] op5_slli = 5'h01;
    localparam logic [4:0] op5_srli = 5'h09;
    localparam logic [4:0] op5_srai = 5'h11;

    localparam logic [3:0] op4_slti  = 4'h8;
    localparam logic [3:0] op4_sltui = 4'h9;
    localparam logic [3:0] op4_addi  = 4'ha;
    localparam logic [3:0] op4_andi  = 4'hd;
    localparam logic [3:0] op4_ori   = 4'he;
    localparam logic [3:0] op4_xori  = 4'hf;

    localparam logic [3:0] op4_ld_b  = 4'h0;
    localparam logic [3:0] op4_ld_h  = 4'h1;
    localparam logic [3:0] op4_ld_w  = 4'h2;
    localparam logic [3:0] op4_st_b  = 4'h4;
    localparam logic [3:0] op4_st_h  = 4'h5;
    localparam logic [3:0] op4_st_w  = 4'h6;
    localparam logic [3:0] op4_ld_bu = 4'h8;
    localparam logic [3:0] op4_ld_hu = 4'h9;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_nor,
        alu_or, alu_xor, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef enum logic [3:0] {
        mem_none, mem_ld_b, mem_ld_h, mem_ld_w, mem_ld_bu, mem_ld_hu,
        mem_st_b, mem_st_h, mem_st_w
    } mem_op_e;

    typedef enum logic [3:0] {
        br_none, br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu,
        br_b, br_bl, br_jirl
    } br_kind_e;

endpackage

`default_nettype wire

// ==== design/decode_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface decode_if;
    import id_pkg::*;

    alu_op_e                alu_op;
    mem_op_e                mem_op;
    br_kind_e               br_kind;
    logic [xlen-1:0]        imm;
    logic [xlen-1:0]        br_offs;
    logic                   src1_is_pc;
    logic                   src2_is_imm;
    logic [reg_addr_w-1:0]  dest;        // 0 when nothing is written
    logic                   gr_we;
    logic [reg_addr_w-1:0]  rj_addr;
    logic [reg_addr_w-1:0]  rkd_addr;
    logic                   uses_rj;
    logic                   uses_rkd;

    modport producer (output alu_op, mem_op, br_kind, imm, br_offs, src1_is_pc, src2_is_imm,
                      dest, gr_we, rj_addr, rkd_addr, uses_rj, uses_rkd);
    modport operand_user (input rj_addr, rkd_addr, uses_rj, uses_rkd);
    modport branch_user (input br_kind, br_offs);
    modport monitor (input alu_op, mem_op, imm, src1_is_pc, src2_is_imm, dest, gr_we,
                     rj_addr, rkd_addr);
endinterface

`default_nettype wire

// ==== design/bypass_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface bypass_if;
    import id_pkg::*;

    logic [reg_addr_w-1:0]  ex_dest;
    logic [xlen-1:0]        ex_value;
    logic                   ex_is_load;  // value not ready yet
    logic [reg_addr_w-1:0]  mem_dest;
    logic [xlen-1:0]        mem_value;
    logic [reg_addr_w-1:0]  wb_dest;
    logic [xlen-1:0]        wb_value;

    modport sink (input ex_dest, ex_value, ex_is_load, mem_dest, mem_value,
                  wb_dest, wb_value);
endinterface

`default_nettype wire

// ==== design/inst_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module inst_decoder (
    input  logic [id_pkg::xlen-1:0] inst,
    decode_if.producer              dec
);
    import id_pkg::*;

    logic [5:0]            op6;
    logic [6:0]            op7;
    logic [3:0]            op4;
    logic [1:0]            op2;
    logic [4:0]            op5;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rk;
    logic known, rj_used, rkd_used, rd_is_src, no_wb, link_r1;
    logic imm_four, imm_si20, imm_ui12, offs_si26;

    assign op6 = inst[31:26];
    assign op7 = inst[31:25];
    assign op4 = inst[25:22];
    assign op2 = inst[21:20];
    assign op5 = inst[19:15];
    assign rd  = inst[4:0];
    assign rk  = inst[14:10];

    always_comb begin
        dec.alu_op      = alu_add;
        dec.mem_op      = mem_none;
        dec.br_kind     = br_none;
        dec.src1_is_pc  = 1'b0;
        dec.src2_is_imm = 1'b0;
        known     = 1'b1;
        rj_used   = 1'b0;
        rkd_used  = 1'b0;
        rd_is_src = 1'b0;
        no_wb     = 1'b0;
        link_r1   = 1'b0;
        imm_four  = 1'b0;
        imm_si20  = 1'b0;
        imm_ui12  = 1'b0;
        offs_si26 = 1'b0;
        if (op6 == op6_alu3r && op4 == op4_3r && op2 == op2_3r) begin
            rj_used  = 1'b1;
            rkd_used = 1'b1;
            case (op5)
                op5_add:  dec.alu_op = alu_add;
                op5_sub:  dec.alu_op = alu_sub;
                op5_slt:  dec.alu_op = alu_slt;
                op5_sltu: dec.alu_op = alu_sltu;
                op5_nor:  dec.alu_op = alu_nor;
                op5_and:  dec.alu_op = alu_and;
                op5_or:   dec.alu_op = alu_or;
                op5_xor:  dec.alu_op = alu_xor;
                op5_sll:  dec.alu_op = alu_sll;
                op5_srl:  dec.alu_op = alu_srl;
                op5_sra:  dec.alu_op = alu_sra;
                default:  known = 1'b0;
            endcase
        end else if (op6 == op6_alui && op4 == op4_shifti && op2 == op2_shifti) begin
            rj_used         = 1'b1;
            dec.src2_is_imm = 1'b1;  // ui5 sits in the low imm bits
            case (op5)
                op5_slli: dec.alu_op = alu_sll;
                op5_srli: dec.alu_op = alu_srl;
                op5_srai: dec.alu_op = alu_sra;
                default:  known = 1'b0;
            endcase
        end else if (op6 == op6_alui) begin
            rj_used         = 1'b1;
            dec.src2_is_imm = 1'b1;
            imm_ui12        = op4 inside {op4_andi, op4_ori, op4_xori};
            case (op4)
                op4_slti:  dec.alu_op = alu_slt;
                op4_sltui: dec.alu_op = alu_sltu;
                op4_addi:  dec.alu_op = alu_add;
                op4_andi:  dec.alu_op = alu_and;
                op4_ori:   dec.alu_op = alu_or;
                op4_xori:  dec.alu_op = alu_xor;
                default:   known = 1'b0;
            endcase
        end else if (op6 == op6_mem) begin
            rj_used         = 1'b1;
            dec.src2_is_imm = 1'b1;  // address is rj + si12
            case (op4)
                op4_ld_b:  dec.mem_op = mem_ld_b;
                op4_ld_h:  dec.mem_op = mem_ld_h;
                op4_ld_w:  dec.mem_op = mem_ld_w;
                op4_ld_bu: dec.mem_op = mem_ld_bu;
                op4_ld_hu: dec.mem_op = mem_ld_hu;
                op4_st_b:  dec.mem_op = mem_st_b;
                op4_st_h:  dec.mem_op = mem_st_h;
                op4_st_w:  dec.mem_op = mem_st_w;
                default:   known = 1'b0;
            endcase
            if (dec.mem_op inside {mem_st_b, mem_st_h, mem_st_w}) begin
                rkd_used  = 1'b1;
                rd_is_src = 1'b1;  // store data comes from rd
                no_wb     = 1'b1;
            end
        end else if (op7 == op7_lu12i) begin
            dec.alu_op      = alu_lui;
            dec.src2_is_imm = 1'b1;
            imm_si20        = 1'b1;
        end else if (op7 == op7_pcaddu12i) begin
            dec.src1_is_pc  = 1'b1;
            dec.src2_is_imm = 1'b1;
            imm_si20        = 1'b1;
        end else begin
            case (op6)
                op6_jirl: dec.br_kind = br_jirl;
                op6_b:    dec.br_kind = br_b;
                op6_bl:   dec.br_kind = br_bl;
                op6_beq:  dec.br_kind = br_beq;
                op6_bne:  dec.br_kind = br_bne;
                op6_blt:  dec.br_kind = br_blt;
                op6_bge:  dec.br_kind = br_bge;
                op6_bltu: dec.br_kind = br_bltu;
                op6_bgeu: dec.br_kind = br_bgeu;
                default:  known = 1'b0;
            endcase
            // link forms write pc + 4
            dec.src1_is_pc  = dec.br_kind inside {br_bl, br_jirl};
            dec.src2_is_imm = dec.br_kind inside {br_bl, br_jirl};
            imm_four        = dec.br_kind inside {br_bl, br_jirl};
            link_r1         = dec.br_kind == br_bl;
            offs_si26       = dec.br_kind inside {br_b, br_bl};
            rj_used         = !(dec.br_kind inside {br_b, br_bl});
            rkd_used        = !(dec.br_kind inside {br_b, br_bl, br_jirl});
            rd_is_src       = rkd_used;
            no_wb           = !(dec.br_kind inside {br_bl, br_jirl});
        end
    end

    assign dec.gr_we    = known && !no_wb;
    assign dec.dest     = dec.gr_we ? (link_r1 ? reg_addr_w'(1) : rd) : '0;
    assign dec.uses_rj  = known && rj_used;
    assign dec.uses_rkd = known && rkd_used;
    assign dec.rj_addr  = inst[9:5];
    assign dec.rkd_addr = rd_is_src ? rd : rk;

    assign dec.imm = imm_four ? xlen'(4) :
                     imm_si20 ? {inst[24:5], 12'b0} :
                     imm_ui12 ? {20'b0, inst[21:10]} :
                                {{20{inst[21]}}, inst[21:10]};

    assign dec.br_offs = offs_si26 ? {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0} :
                                     {{14{inst[25]}}, inst[25:10], 2'b0};
endmodule

`default_nettype wire

// ==== design/operand_bypass.sv ====
`timescale 1ns/1ns
`default_nettype none

module operand_bypass (
    decode_if.operand_user          dec,
    bypass_if.sink                  byp,
    input  logic [id_pkg::xlen-1:0] rf_rdata1,
    input  logic [id_pkg::xlen-1:0] rf_rdata2,
    output logic [id_pkg::xlen-1:0] rj_value,
    output logic [id_pkg::xlen-1:0] rkd_value,
    output logic                    load_stall
);
    import id_pkg::*;

    logic rj_live;
    logic rkd_live;

    // newest producer first
    function automatic logic [xlen-1:0] pick(input logic [reg_addr_w-1:0] addr,
                                             input logic live,
                                             input logic [xlen-1:0] rf_data);
        logic [xlen-1:0] val;
        val = rf_data;
        if (live) begin
            if (addr == byp.ex_dest)
                val = byp.ex_value;
            else if (addr == byp.mem_dest)
                val = byp.mem_value;
            else if (addr == byp.wb_dest)
                val = byp.wb_value;
        end
        return val;
    endfunction

    assign rj_live  = dec.uses_rj && dec.rj_addr != '0;   // r0 never bypassed
    assign rkd_live = dec.uses_rkd && dec.rkd_addr != '0;

    always_comb begin
        rj_value  = pick(dec.rj_addr, rj_live, rf_rdata1);
        rkd_value = pick(dec.rkd_addr, rkd_live, rf_rdata2);
    end

    // load data only shows up after MEM
    assign load_stall = byp.ex_is_load &&
                        ((rj_live && dec.rj_addr == byp.ex_dest) ||
                         (rkd_live && dec.rkd_addr == byp.ex_dest));
endmodule

`default_nettype wire

// ==== design/branch_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module branch_unit (
    decode_if.branch_user           dec,
    input  logic [id_pkg::xlen-1:0] pc,
    input  logic [id_pkg::xlen-1:0] rj_value,
    input  logic [id_pkg::xlen-1:0] rkd_value,
    output logic                    taken_raw,
    output logic [id_pkg::xlen-1:0] target
);
    import id_pkg::*;

    logic eq;
    logic lt;
    logic ltu;

    assign eq  = rj_value == rkd_value;
    assign lt  = $signed(rj_value) < $signed(rkd_value);
    assign ltu = rj_value < rkd_value;

    always_comb begin
        case (dec.br_kind)
            br_beq:  taken_raw = eq;
            br_bne:  taken_raw = !eq;
            br_blt:  taken_raw = lt;
            br_bge:  taken_raw = !lt;
            br_bltu: taken_raw = ltu;
            br_bgeu: taken_raw = !ltu;
            br_b, br_bl, br_jirl: taken_raw = 1'b1;
            default: taken_raw = 1'b0;
        endcase
    end

    // jirl is register relative
    assign target = (dec.br_kind == br_jirl ? rj_value : pc) + dec.br_offs;
endmodule

`default_nettype wire

// ==== design/id_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module id_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          if_valid,
    input  logic [id_pkg::xlen-1:0]       in_pc,
    input  logic [id_pkg::xlen-1:0]       in_inst,
    output logic                          id_allow_in,
    input  logic                          ex_allow_in,
    output logic                          ex_valid,
    output logic [id_pkg::xlen-1:0]       ex_pc,
    output logic [id_pkg::xlen-1:0]       ex_rj_value,
    output logic [id_pkg::xlen-1:0]       ex_rkd_value,
    output logic [id_pkg::xlen-1:0]       ex_imm,
    output id_pkg::alu_op_e               ex_alu_op,
    output id_pkg::mem_op_e               ex_mem_op,
    output logic                          ex_src1_is_pc,
    output logic                          ex_src2_is_imm,
    output logic [id_pkg::reg_addr_w-1:0] ex_dest,
    output logic                          ex_gr_we,
    output logic                          br_taken,
    output logic [id_pkg::xlen-1:0]       br_target,
    output logic [id_pkg::reg_addr_w-1:0] rf_raddr1,
    input  logic [id_pkg::xlen-1:0]       rf_rdata1,
    output logic [id_pkg::reg_addr_w-1:0] rf_raddr2,
    input  logic [id_pkg::xlen-1:0]       rf_rdata2,
    input  logic [id_pkg::reg_addr_w-1:0] fwd_ex_dest,
    input  logic [id_pkg::xlen-1:0]       fwd_ex_value,
    input  logic                          fwd_ex_is_load,
    input  logic [id_pkg::reg_addr_w-1:0] fwd_mem_dest,
    input  logic [id_pkg::xlen-1:0]       fwd_mem_value,
    input  logic [id_pkg::reg_addr_w-1:0] fwd_wb_dest,
    input  logic [id_pkg::xlen-1:0]       fwd_wb_value
);
    import id_pkg::*;

    logic            id_valid;
    logic [xlen-1:0] pc_r;
    logic [xlen-1:0] inst_r;
    logic            load_stall;
    logic            taken_raw;

    decode_if dec ();
    bypass_if byp ();

    assign byp.ex_dest    = fwd_ex_dest;
    assign byp.ex_value   = fwd_ex_value;
    assign byp.ex_is_load = fwd_ex_is_load;
    assign byp.mem_dest   = fwd_mem_dest;
    assign byp.mem_value  = fwd_mem_value;
    assign byp.wb_dest    = fwd_wb_dest;
    assign byp.wb_value   = fwd_wb_value;

    inst_decoder u_dec (.inst(inst_r), .dec(dec));

    operand_bypass u_byp (
        .dec(dec), .byp(byp),
        .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
        .rj_value(ex_rj_value), .rkd_value(ex_rkd_value),
        .load_stall(load_stall)
    );

    branch_unit u_br (
        .dec(dec), .pc(pc_r),
        .rj_value(ex_rj_value), .rkd_value(ex_rkd_value),
        .taken_raw(taken_raw), .target(br_target)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // handshake
    assign ex_valid    = id_valid && !load_stall;
    assign id_allow_in = !id_valid || (!load_stall && ex_allow_in);
    assign br_taken    = taken_raw && ex_valid;  // no redirect from a stalled slot

    always_ff @(posedge clk) begin
        if (reset)
            id_valid <= 1'b0;
        else if (br_taken && ex_allow_in)
            id_valid <= 1'b0;                    // squash the fetch behind it
        else if (id_allow_in)
            id_valid <= if_valid;
    end

    always_ff @(posedge clk) begin
        if (if_valid && id_allow_in) begin
            pc_r   <= in_pc;
            inst_r <= in_inst;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bundle to EX
    assign ex_pc          = pc_r;
    assign ex_imm         = dec.imm;
    assign ex_alu_op      = dec.alu_op;
    assign ex_mem_op      = dec.mem_op;
    assign ex_src1_is_pc  = dec.src1_is_pc;
    assign ex_src2_is_imm = dec.src2_is_imm;
    assign ex_dest        = dec.dest;
    assign ex_gr_we       = dec.gr_we;
    assign rf_raddr1      = dec.rj_addr;
    assign rf_raddr2      = dec.rkd_addr;
endmodule

`default_nettype wire

// ==== testbench/id_stage_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module id_stage_props (
    input logic                    clk,
    input logic                    reset,
    input logic                    ex_valid,
    input logic                    br_taken,
    input logic                    ex_allow_in,
    input logic [id_pkg::xlen-1:0] ex_pc
);
    import id_pkg::*;

    a_idle_in_reset: assert property (@(posedge clk) reset |=> !ex_valid)
        else $error("ex_valid seen after a reset edge");

    a_taken_squash: assert property (@(posedge clk) disable iff (reset)
                                     br_taken && ex_allow_in |=> !ex_valid)
        else $error("slot behind a taken branch was not squashed");

    a_hold_pc: assert property (@(posedge clk) disable iff (reset)
                                ex_valid && !ex_allow_in |=> $stable(ex_pc))
        else $error("ex_pc moved under back-pressure");
endmodule

bind id_stage id_stage_props props (
    .clk(clk), .reset(reset), .ex_valid(ex_valid), .br_taken(br_taken),
    .ex_allow_in(ex_allow_in), .ex_pc(ex_pc)
);

`default_nettype wire

// ==== testbench/tb_id_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_id_stage;
    import id_pkg::*;

    typedef struct packed {
        logic [xlen-1:0]       pc, inst, rf1, rf2, exv, memv, wbv;
        logic [reg_addr_w-1:0] exd, memd, wbd;
        logic                  exl, allow;
        alu_op_e               alu;
        mem_op_e               mem;
        logic [reg_addr_w-1:0] dest, raddr1, raddr2;
        logic                  we, src1_pc, src2_imm, taken, stall, is_br;
        logic [xlen-1:0]       imm, rj, rkd, target;
    } case_t;

    logic clk, reset, if_valid, ex_allow_in, fwd_ex_is_load;
    logic [xlen-1:0] in_pc, in_inst, rf_rdata1, rf_rdata2;
    logic [xlen-1:0] fwd_ex_value, fwd_mem_value, fwd_wb_value;
    logic [reg_addr_w-1:0] fwd_ex_dest, fwd_mem_dest, fwd_wb_dest, rf_raddr1, rf_raddr2;
    logic id_allow_in, ex_valid, ex_src1_is_pc, ex_src2_is_imm, ex_gr_we, br_taken;
    logic [xlen-1:0] ex_pc, ex_rj_value, ex_rkd_value, ex_imm, br_target;
    logic [reg_addr_w-1:0] ex_dest;
    alu_op_e ex_alu_op;
    mem_op_e ex_mem_op;

    case_t     cases[$];
    case_t     e;
    integer    seed = 32'h7f7c_ceaa;

    id_stage uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction builders
    function automatic logic [xlen-1:0] r3_word(logic [4:0] op5, logic [4:0] rd,
                                                logic [4:0] rj, logic [4:0] rk);
        return {op6_alu3r, op4_3r, op2_3r, op5, rk, rj, rd};
    endfunction

    function automatic logic [xlen-1:0] ri12_word(logic [5:0] op6, logic [3:0] op4,
                                                  logic [4:0] rd, logic [4:0] rj,
                                                  logic [11:0] si12);
        return {op6, op4, si12, rj, rd};
    endfunction

    function automatic logic [xlen-1:0] br16_word(logic [5:0] op6, logic [4:0] rd,
                                                  logic [4:0] rj, logic [15:0] offs);
        return {op6, offs, rj, rd};
    endfunction

    function automatic logic [xlen-1:0] sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_alu(input alu_op_e got, input alu_op_e exp, input string name);
        if (got !== exp)
            fail_now($sformatf("mismatch at %0t: %s got %s expected %s",
                               $time, name, got.name(), exp.name()));
    endtask

    task automatic check_mem(input mem_op_e got, input mem_op_e exp, input string name);
        if (got !== exp)
            fail_now($sformatf("mismatch at %0t: %s got %s expected %s",
                               $time, name, got.name(), exp.name()));
    endtask

    task automatic check_word(input logic [xlen-1:0] got, input logic [xlen-1:0] exp,
                              input string name);
        if (got !== exp)
            fail_now($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_reg(input logic [reg_addr_w-1:0] got,
                             input logic [reg_addr_w-1:0] exp, input string name);
        if (got !== exp)
            fail_now($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp)
            fail_now($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    endtask

    // defaults follow the decode rules
    task automatic start_case(input logic [xlen-1:0] pc, input logic [xlen-1:0] inst);
        e.pc = pc;
        e.inst = inst;
        e.rf1 = $random(seed);
        e.rf2 = $random(seed);
        e.exv = $random(seed);
        e.memv = $random(seed);
        e.wbv = $random(seed);
        e.exd = '0;
        e.memd = '0;
        e.wbd = '0;
        e.exl = 1'b0;
        e.allow = 1'b1;
        e.alu = alu_add;
        e.mem = mem_none;
        e.dest = inst[4:0];
        e.raddr1 = inst[9:5];
        e.raddr2 = inst[14:10];
        e.we = 1'b1;
        e.src1_pc = 1'b0;
        e.src2_imm = 1'b0;
        e.taken = 1'b0;
        e.stall = 1'b0;
        e.is_br = 1'b0;
        e.imm = sext12(inst[21:10]);
        e.rj = e.rf1;
        e.rkd = e.rf2;
        e.target = '0;
    endtask

    task automatic build_table();
        start_case(32'h1c00_0000, r3_word(op5_add, 3, 1, 2));
        cases.push_back(e);
        start_case(32'h1c00_0004, r3_word(op5_sub, 4, 5, 5));
        e.exd = 5;
        e.memd = 5;
        e.wbd = 5;
        e.alu = alu_sub;
        e.rj = e.exv;
        e.rkd = e.exv;
        cases.push_back(e);
        start_case(32'h1c00_0008, r3_word(op5_xor, 6, 7, 9));
        e.memd = 7;
        e.wbd = 7;
        e.alu = alu_xor;
        e.rj = e.memv;
        cases.push_back(e);
        start_case(32'h1c00_000c, r3_word(op5_nor, 6, 2, 8));
        e.wbd = 8;
        e.alu = alu_nor;
        e.rkd = e.wbv;
        cases.push_back(e);
        start_case(32'h1c00_0010, r3_word(op5_or, 4, 0, 0));  // r0 stays on rf data
        e.alu = alu_or;
        cases.push_back(e);
        start_case(32'h1c00_0014, ri12_word(op6_alui, op4_addi, 6, 1, 12'hffc));
        e.src2_imm = 1'b1;
        e.imm = 32'hffff_fffc;
        cases.push_back(e);
        start_case(32'h1c00_0018, ri12_word(op6_alui, op4_ori, 6, 1, 12'h800));
        e.alu = alu_or;
        e.src2_imm = 1'b1;
        e.imm = 32'h0000_0800;
        cases.push_back(e);
        start_case(32'h1c00_001c, {op6_alui, op4_shifti, op2_shifti, op5_slli, 5'd5,
                                   5'd1, 5'd2});
        e.alu = alu_sll;
        e.src2_imm = 1'b1;
        e.imm = 32'h0000_0025;
        cases.push_back(e);
        start_case(32'h1c00_0020, {op7_lu12i, 20'h12345, 5'd10});
        e.alu = alu_lui;
        e.src2_imm = 1'b1;
        e.imm = 32'h1234_5000;
        cases.push_back(e);
        start_case(32'h1c00_0024, ri12_word(op6_mem, op4_ld_w, 11, 1, 12'h008));
        e.mem = mem_ld_w;
        e.src2_imm = 1'b1;
        e.raddr2 = 8;
        cases.push_back(e);
        start_case(32'h1c00_0028, ri12_word(op6_mem, op4_st_w, 12, 1, 12'h004));
        e.mem = mem_st_w;
        e.src2_imm = 1'b1;
        e.we = 1'b0;
        e.dest = 0;
        e.raddr2 = 12;
        cases.push_back(e);
        start_case(32'h1c00_002c, r3_word(op5_add, 3, 13, 2));  // load-use on r13
        e.exd = 13;
        e.exl = 1'b1;
        e.stall = 1'b1;
        e.rj = e.exv;
        cases.push_back(e);
        start_case(32'h1c00_1000, br16_word(op6_beq, 2, 1, 16'h0004));
        e.rf2 = e.rf1;
        e.rkd = e.rf1;
        e.we = 1'b0;
        e.dest = 0;
        e.raddr2 = 2;
        e.taken = 1'b1;
        e.is_br = 1'b1;
        e.target = 32'h1c00_1010;
        cases.push_back(e);
        start_case(32'h1c00_2000, br16_word(op6_blt, 2, 1, 16'hfffe));
        e.rf1 = 5;
        e.rf2 = 32'hffff_fffd;
        e.rj = 5;
        e.rkd = 32'hffff_fffd;
        e.we = 1'b0;
        e.dest = 0;
        e.raddr2 = 2;
        e.is_br = 1'b1;
        e.target = 32'h1c00_1ff8;
        cases.push_back(e);
        e.inst = br16_word(op6_bltu, 2, 1, 16'hfffe);
        e.taken = 1'b1;  // same values under an unsigned compare
        cases.push_back(e);
        start_case(32'h1c00_3000, {op6_bl, 16'h0040, 10'h000});
        e.dest = 1;
        e.imm = 4;
        e.src1_pc = 1'b1;
        e.src2_imm = 1'b1;
        e.taken = 1'b1;
        e.is_br = 1'b1;
        e.target = 32'h1c00_3100;
        cases.push_back(e);
        start_case(32'h1c00_4000, br16_word(op6_jirl, 5, 1, 16'h0002));
        e.imm = 4;
        e.src1_pc = 1'b1;
        e.src2_imm = 1'b1;
        e.taken = 1'b1;
        e.is_br = 1'b1;
        e.target = e.rf1 + 8;
        cases.push_back(e);
        start_case(32'h1c00_5000, ri12_word(op6_alui, op4_addi, 7, 3, 12'h123));
        e.src2_imm = 1'b1;
        e.allow = 1'b0;
        cases.push_back(e);
        start_case(32'h1c00_6000, 32'hfc00_0000);  // unknown word
        e.we = 1'b0;
        e.dest = 0;
        e.imm = 0;
        cases.push_back(e);
    endtask

    task automatic check_outputs(input case_t c);
        check_bit(ex_valid, !c.stall, "ex_valid");
        check_alu(ex_alu_op, c.alu, "ex_alu_op");
        check_mem(ex_mem_op, c.mem, "ex_mem_op");
        check_reg(ex_dest, c.dest, "ex_dest");
        check_bit(ex_gr_we, c.we, "ex_gr_we");
        check_bit(ex_src1_is_pc, c.src1_pc, "ex_src1_is_pc");
        check_bit(ex_src2_is_imm, c.src2_imm, "ex_src2_is_imm");
        check_reg(rf_raddr1, c.raddr1, "rf_raddr1");
        check_reg(rf_raddr2, c.raddr2, "rf_raddr2");
        check_word(ex_imm, c.imm, "ex_imm");
        check_word(ex_pc, c.pc, "ex_pc");
        check_word(ex_rj_value, c.rj, "ex_rj_value");
        check_word(ex_rkd_value, c.rkd, "ex_rkd_value");
        check_bit(br_taken, c.taken && !c.stall, "br_taken");
        if (c.is_br)
            check_word(br_target, c.target, "br_target");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    initial begin
        reset <= 1'b1;
        if_valid <= 1'b0;
        ex_allow_in <= 1'b1;
        in_pc <= '0;
        in_inst <= '0;
        rf_rdata1 <= '0;
        rf_rdata2 <= '0;
        fwd_ex_dest <= '0;
        fwd_ex_value <= '0;
        fwd_ex_is_load <= 1'b0;
        fwd_mem_dest <= '0;
        fwd_mem_value <= '0;
        fwd_wb_dest <= '0;
        fwd_wb_value <= '0;
        build_table();
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        foreach (cases[i]) begin
            @(posedge clk);
            if_valid <= 1'b1;
            in_pc <= cases[i].pc;
            in_inst <= cases[i].inst;
            rf_rdata1 <= cases[i].rf1;
            rf_rdata2 <= cases[i].rf2;
            fwd_ex_dest <= cases[i].exd;
            fwd_ex_value <= cases[i].exv;
            fwd_ex_is_load <= cases[i].exl;
            fwd_mem_dest <= cases[i].memd;
            fwd_mem_value <= cases[i].memv;
            fwd_wb_dest <= cases[i].wbd;
            fwd_wb_value <= cases[i].wbv;
            ex_allow_in <= cases[i].allow;
            @(posedge clk);
            if_valid <= cases[i].taken || !cases[i].allow;  // filler behind a branch or a held slot
            in_pc <= cases[i].pc + 4;
            in_inst <= r3_word(op5_add, 3, 1, 2);
            #1;
            check_outputs(cases[i]);
            if (cases[i].stall) begin
                @(posedge clk);
                fwd_ex_is_load <= 1'b0;
                #1;
                while (!ex_valid) begin
                    @(posedge clk);
                    #1;
                end
                check_word(ex_rj_value, cases[i].rj, "ex_rj_value");
            end else if (cases[i].taken) begin
                @(posedge clk);
                if_valid <= 1'b0;
                #1;
                check_bit(ex_valid, 1'b0, "ex_valid after taken branch");
            end else if (!cases[i].allow) begin
                check_bit(id_allow_in, 1'b0, "id_allow_in");
                repeat (3) @(posedge clk);
                #1;
                check_word(ex_pc, cases[i].pc, "ex_pc held");
                check_word(ex_imm, cases[i].imm, "ex_imm held");
                check_bit(ex_valid, 1'b1, "ex_valid held");
                @(posedge clk);
                ex_allow_in <= 1'b1;
                if_valid <= 1'b0;
            end
        end
        repeat (2) @(posedge clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

    initial begin
        #1;
        repeat (cases.size() * 8 + 40) @(posedge clk);
        fail_now("timeout: the stage stopped making progress");
    end
endmodule

`default_nettype wire

// ==== all.f ====
design/id_pkg.sv
design/decode_if.sv
design/bypass_if.sv
design/inst_decoder.sv
design/operand_bypass.sv
design/branch_unit.sv
design/id_stage.sv
testbench/id_stage_props.sv
testbench/tb_id_stage.sv
